/* logic/rs_key_pkg.sv */
package rs_key_pkg;

   //////////////////////////////////////////////////
   // field and job sizes
   //////////////////////////////////////////////////
   localparam int SYM_W      = 8;        // bits per GF(256) symbol
   localparam int NUM_SYN    = 16;       // syndromes in, omega coefficients out
   localparam int NUM_LAMBDA = 8;        // lambda terms after the implied 1
   localparam int NUM_PHI    = 4;        // odd lambda terms only
   localparam int JOB_DEPTH  = 2;        // pending jobs in the buffer

   // x^8 + x^4 + x^3 + x^2 + 1, top bit dropped
   localparam logic [SYM_W-1:0] GF_POLY = 8'h1D;

   //////////////////////////////////////////////////
   // symbol vectors, all in polynomial form
   //////////////////////////////////////////////////
   typedef logic [SYM_W-1:0] gf_sym_t;

   typedef gf_sym_t [NUM_SYN:1]    syn_vec_t;      // index 1 = S1
   typedef gf_sym_t [NUM_LAMBDA:1] lambda_vec_t;   // index 1 = L1
   typedef gf_sym_t [NUM_SYN:1]    omega_vec_t;    // index 1 = O1
   typedef gf_sym_t [NUM_PHI:1]    phi_vec_t;      // 1..4 = P1, P3, P5, P7

   //////////////////////////////////////////////////
   // shift-and-xor multiply, reduced every step
   //////////////////////////////////////////////////
   function automatic gf_sym_t gf_mul(input gf_sym_t a, input gf_sym_t b);
      gf_sym_t acc;
      gf_sym_t sh;
      acc = '0;
      sh  = a;
      for (int i = 0; i < SYM_W; i++)
      begin
         if (b[i])
            acc = acc ^ sh;                               // add a * x^i
         if (sh[SYM_W-1])
            sh = {sh[SYM_W-2:0], 1'b0} ^ GF_POLY;         // fold x^8 back in
         else
            sh = {sh[SYM_W-2:0], 1'b0};
      end
      return acc;
   endfunction

endpackage

/* logic/key_capture.sv */
module key_capture
(
   input  logic                    clk,
   input  logic                    reset,

   // syndrome load, one-cycle pulse
   input  logic                    syn_valid,
   input  rs_key_pkg::syn_vec_t    syn,

   // lambda load, one-cycle pulse
   input  logic                    lambda_valid,
   input  rs_key_pkg::lambda_vec_t lambda,

   input  logic                    in_ready,     // buffer has room

   // job write toward the buffer
   output logic                    wr_en,
   output rs_key_pkg::syn_vec_t    wr_syn,
   output rs_key_pkg::lambda_vec_t wr_lambda
);

   rs_key_pkg::syn_vec_t syn_q;      // held syndrome set
   rs_key_pkg::syn_vec_t syn_sel;    // syndromes paired with this lambda
   logic                 accept;     // lambda taken this edge

   //////////////////////////////////////////////////
   // acceptance
   //////////////////////////////////////////////////
   assign accept = lambda_valid & in_ready;   // pulses while full are dropped

   // fresh syndromes win when both pulses coincide
   assign syn_sel = syn_valid ? syn : syn_q;

   //////////////////////////////////////////////////
   // syndrome hold and job payload
   //////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (syn_valid)
         syn_q <= syn;                // kept until next syn_valid
      if (accept)
      begin
         wr_syn    <= syn_sel;
         wr_lambda <= lambda;
      end
   end

   //////////////////////////////////////////////////
   // write strobe, one cycle after acceptance
   //////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_en <= 1'b0;
      end
      else
      begin
         wr_en <= accept;             // single-cycle pulse per job
      end
   end

endmodule

/* logic/job_buffer.sv */
module job_buffer
(
   input  logic                    clk,
   input  logic                    reset,

   // write side from capture
   input  logic                    wr_en,
   input  rs_key_pkg::syn_vec_t    wr_syn,
   input  rs_key_pkg::lambda_vec_t wr_lambda,
   output logic                    in_ready,

   // read side toward the engine
   input  logic                    pop,
   output logic                    not_empty,
   output rs_key_pkg::syn_vec_t    head_syn,
   output rs_key_pkg::lambda_vec_t head_lambda
);

   localparam int PTR_W = $clog2(rs_key_pkg::JOB_DEPTH);
   localparam int CNT_W = $clog2(rs_key_pkg::JOB_DEPTH + 1);

   rs_key_pkg::syn_vec_t    syn_mem    [rs_key_pkg::JOB_DEPTH];  // job storage
   rs_key_pkg::lambda_vec_t lambda_mem [rs_key_pkg::JOB_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;          // entries held
   logic             wr_ok;          // write really lands
   logic             pop_ok;         // head really leaves

   //////////////////////////////////////////////////
   // status from the count only
   //////////////////////////////////////////////////
   assign not_empty = (count != '0);
   // a strobe already in flight takes a slot too
   assign in_ready  = ({1'b0, count} + (CNT_W + 1)'(wr_en)) < rs_key_pkg::JOB_DEPTH;

   assign pop_ok = pop & not_empty;
   assign wr_ok  = wr_en & ((count < rs_key_pkg::JOB_DEPTH) | pop_ok);  // full plus pop is ok

   assign head_syn    = syn_mem[rd_ptr];      // oldest job
   assign head_lambda = lambda_mem[rd_ptr];

   // job storage writes
   always_ff @(posedge clk)
   begin
      if (wr_ok)
      begin
         syn_mem[wr_ptr]    <= wr_syn;
         lambda_mem[wr_ptr] <= wr_lambda;
      end
   end

   //////////////////////////////////////////////////
   // pointers and count
   //////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_ok)
            wr_ptr <= (wr_ptr == PTR_W'(rs_key_pkg::JOB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop_ok)
            rd_ptr <= (rd_ptr == PTR_W'(rs_key_pkg::JOB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (wr_ok && !pop_ok)
            count <= count + 1'b1;
         else if (pop_ok && !wr_ok)
            count <= count - 1'b1;    // both at once leaves it alone
      end
   end

endmodule

/* logic/omega_engine.sv */
module omega_engine
(
   input  logic                    clk,
   input  logic                    reset,

   // head of the job buffer
   input  logic                    not_empty,
   input  rs_key_pkg::syn_vec_t    head_syn,
   input  rs_key_pkg::lambda_vec_t head_lambda,
   output logic                    pop,

   // results held until the next job finishes
   output logic                    poly_ready,
   output rs_key_pkg::omega_vec_t  omega,
   output rs_key_pkg::phi_vec_t    phi
);

   localparam int K_W = $clog2(rs_key_pkg::NUM_SYN + 1);     // k runs 2..16
   localparam int J_W = $clog2(rs_key_pkg::NUM_LAMBDA + 1);  // j runs 1..8

   logic                    busy;        // products in progress
   logic [K_W-1:0]          k;           // coefficient being built
   logic [J_W-1:0]          j;           // lambda term index
   logic [K_W-1:0]          s_idx;       // syndrome index k - j
   logic                    j_last;      // last term of this coefficient
   logic                    done;        // last product of the job

   rs_key_pkg::syn_vec_t    syn_w;       // working syndromes
   rs_key_pkg::lambda_vec_t lam_w;       // working lambda
   rs_key_pkg::omega_vec_t  acc;         // omega accumulators
   rs_key_pkg::omega_vec_t  acc_upd;     // acc with this cycle's product
   rs_key_pkg::gf_sym_t     prod;        // L_j * S_(k-j)

   //////////////////////////////////////////////////
   // term sequencing
   //////////////////////////////////////////////////
   assign pop    = ~busy & not_empty;              // take head when idle
   assign s_idx  = k - K_W'(j);
   assign j_last = (j == J_W'(rs_key_pkg::NUM_LAMBDA)) || (K_W'(j) == k - 1'b1);
   assign done   = busy & j_last & (k == K_W'(rs_key_pkg::NUM_SYN));

   //////////////////////////////////////////////////
   // one product per cycle
   //////////////////////////////////////////////////
   assign prod = rs_key_pkg::gf_mul(lam_w[j], syn_w[s_idx]);

   always_comb
   begin
      acc_upd    = acc;
      acc_upd[k] = acc[k] ^ prod;                  // xor is the field add
   end

   // job payload
   always_ff @(posedge clk)
   begin
      if (pop)
      begin
         acc   <= head_syn;                        // O_k starts at S_k
         syn_w <= head_syn;
         lam_w <= head_lambda;
      end
      else if (busy)
      begin
         acc <= acc_upd;
      end
   end

   //////////////////////////////////////////////////
   // control and result registers
   //////////////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         k          <= K_W'(2);
         j          <= J_W'(1);
         poly_ready <= 1'b0;
         omega      <= '0;
         phi        <= '0;
      end
      else
      begin
         poly_ready <= 1'b0;                       // single-cycle flag
         if (pop)
         begin
            busy <= 1'b1;
            k    <= K_W'(2);                       // O1 needs no products
            j    <= J_W'(1);
         end
         else if (busy)
         begin
            if (j_last)
            begin
               k <= k + 1'b1;                      // next coefficient
               j <= J_W'(1);
            end
            else
            begin
               j <= j + 1'b1;
            end
            if (done)
            begin
               busy       <= 1'b0;
               poly_ready <= 1'b1;
               omega      <= acc_upd;              // includes the final product
               for (int i = 1; i <= rs_key_pkg::NUM_PHI; i++)
               begin
                  phi[i] <= lam_w[2*i-1];          // odd terms survive d/dx
               end
            end
         end
      end
   end

endmodule

/* logic/omega_phi.sv */
module omega_phi
(
   input  logic                    clk,
   input  logic                    reset,

   // job inputs
   input  logic                    syn_valid,
   input  rs_key_pkg::syn_vec_t    syn,
   input  logic                    lambda_valid,
   input  rs_key_pkg::lambda_vec_t lambda,
   output logic                    in_ready,

   // results
   output logic                    poly_ready,
   output rs_key_pkg::omega_vec_t  omega,
   output rs_key_pkg::phi_vec_t    phi
);

   logic                    wr_en;        // capture to buffer
   rs_key_pkg::syn_vec_t    wr_syn;
   rs_key_pkg::lambda_vec_t wr_lambda;

   logic                    not_empty;    // buffer to engine
   logic                    pop;
   rs_key_pkg::syn_vec_t    head_syn;
   rs_key_pkg::lambda_vec_t head_lambda;

   //////////////////////////////////////////////////
   // producer, buffer, consumer
   //////////////////////////////////////////////////
   key_capture key_capture_i
   (
      .clk          (clk),
      .reset        (reset),
      .syn_valid    (syn_valid),
      .syn          (syn),
      .lambda_valid (lambda_valid),
      .lambda       (lambda),
      .in_ready     (in_ready),
      .wr_en        (wr_en),
      .wr_syn       (wr_syn),
      .wr_lambda    (wr_lambda)
   );

   job_buffer job_buffer_i
   (
      .clk          (clk),
      .reset        (reset),
      .wr_en        (wr_en),
      .wr_syn       (wr_syn),
      .wr_lambda    (wr_lambda),
      .in_ready     (in_ready),
      .pop          (pop),
      .not_empty    (not_empty),
      .head_syn     (head_syn),
      .head_lambda  (head_lambda)
   );

   omega_engine omega_engine_i
   (
      .clk          (clk),
      .reset        (reset),
      .not_empty    (not_empty),
      .head_syn     (head_syn),
      .head_lambda  (head_lambda),
      .pop          (pop),
      .poly_ready   (poly_ready),
      .omega        (omega),
      .phi          (phi)
   );

endmodule

/* tb/omega_phi_tb_tasks.svh */
`ifndef OMEGA_PHI_TB_TASKS_SVH
`define OMEGA_PHI_TB_TASKS_SVH

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////
function automatic rs_key_pkg::gf_sym_t field_mul(input rs_key_pkg::gf_sym_t a,
                                                  input rs_key_pkg::gf_sym_t b);
   logic [15:0] full;
   full = '0;
   for (int i = 0; i < 8; i++)
      if (b[i])
         full = full ^ (16'(a) << i);                    // carry-less product first
   for (int i = 15; i >= 8; i--)
      if (full[i])
         full = full ^ (16'h011D << (i - 8));            // then reduce from the top
   return full[7:0];
endfunction

function automatic rs_key_pkg::omega_vec_t model_omega(input rs_key_pkg::syn_vec_t s,
                                                       input rs_key_pkg::lambda_vec_t l);
   rs_key_pkg::omega_vec_t o;
   for (int k = 1; k <= 16; k++)
   begin
      o[k] = s[k];                                      // implied L0 = 1
      for (int j = 1; j <= 8 && j <= k - 1; j++)
         o[k] = o[k] ^ field_mul(l[j], s[k-j]);
   end
   return o;
endfunction

function automatic rs_key_pkg::phi_vec_t model_phi(input rs_key_pkg::lambda_vec_t l);
   rs_key_pkg::phi_vec_t p;
   p[1] = l[1];
   p[2] = l[3];
   p[3] = l[5];
   p[4] = l[7];                                         // even terms drop out
   return p;
endfunction

function automatic rs_key_pkg::syn_vec_t random_syn();
   rs_key_pkg::syn_vec_t v;
   for (int i = 1; i <= 16; i++)
      v[i] = 8'($urandom());
   return v;
endfunction

function automatic rs_key_pkg::lambda_vec_t random_lambda();
   rs_key_pkg::lambda_vec_t v;
   for (int i = 1; i <= 8; i++)
      v[i] = 8'($urandom());
   return v;
endfunction

//////////////////////////////////////////////////
// drive tasks
//////////////////////////////////////////////////
task automatic wait_ready();
   @(negedge clk);
   while (!in_ready)
      @(negedge clk);                                   // room in the buffer
endtask

task automatic load_syn(input rs_key_pkg::syn_vec_t s);
   @(posedge clk);
   syn_valid <= 1'b1;
   syn       <= s;
   @(posedge clk);
   syn_valid <= 1'b0;
   syn       <= ~s;                                     // bus no longer carries the held set
endtask

// s is the set the job pairs with whether fresh or held
task automatic send_job(input logic with_syn, input rs_key_pkg::syn_vec_t s,
                        input rs_key_pkg::lambda_vec_t l);
   wait_ready();
   @(posedge clk);
   lambda_valid <= 1'b1;
   lambda       <= l;
   if (with_syn)
   begin
      syn_valid <= 1'b1;
      syn       <= s;
   end
   @(posedge clk);                                      // accepted at this edge
   lambda_valid <= 1'b0;
   syn_valid    <= 1'b0;
   exp_omega.push_back(model_omega(s, l));
   exp_phi.push_back(model_phi(l));
endtask

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////
task automatic compare_flag(input string what, input logic got, input logic exp);
   if (got !== exp)
   begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
   end
endtask

task automatic compare_omega(input rs_key_pkg::omega_vec_t got,
                             input rs_key_pkg::omega_vec_t exp);
   for (int i = 1; i <= rs_key_pkg::NUM_SYN; i++)
      if (got[i] !== exp[i])
      begin
         $display("mismatch at %0t: omega[%0d] is %h, expected %h", $time, i, got[i], exp[i]);
         error_count++;
      end
endtask

task automatic compare_phi(input rs_key_pkg::phi_vec_t got, input rs_key_pkg::phi_vec_t exp);
   for (int i = 1; i <= rs_key_pkg::NUM_PHI; i++)
      if (got[i] !== exp[i])
      begin
         $display("mismatch at %0t: phi[%0d] is %h, expected %h", $time, i, got[i], exp[i]);
         error_count++;
      end
endtask

// wait for n results and check them in order against the model
task automatic collect_results(input int n);
   int waited;
   waited = 0;
   while (got_omega.size() < n && waited < n * JOB_CYCLES)
   begin
      @(posedge clk);
      waited++;
   end
   if (got_omega.size() < n)
   begin
      $display("error at %0t: only %0d of %0d results arrived", $time, got_omega.size(), n);
      error_count++;
   end
   while (got_omega.size() > 0 && exp_omega.size() > 0)
   begin
      compare_omega(got_omega.pop_front(), exp_omega.pop_front());
      compare_phi(got_phi.pop_front(), exp_phi.pop_front());
   end
   exp_omega.delete();
   exp_phi.delete();
endtask

task automatic close_test(input string name, input int errors_before);
   if (error_count == errors_before)
   begin
      tests_passed++;
      $display("test %s: ok", name);
   end
   else
   begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - errors_before);
   end
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////
task automatic test_reset_state();
   int e0;
   e0 = error_count;
   @(negedge clk);
   compare_flag("poly_ready after reset", poly_ready, 1'b0);
   compare_flag("in_ready after reset", in_ready, 1'b1);
   close_test("reset_state", e0);
endtask

task automatic test_zero_lambda();
   int e0;
   e0 = error_count;
   send_job(1'b1, random_syn(), '0);                    // omega comes back as the syndromes
   collect_results(1);
   close_test("zero_lambda", e0);
endtask

task automatic test_single_term();
   int                      e0;
   rs_key_pkg::lambda_vec_t l;
   e0   = error_count;
   l    = '0;
   l[1] = 8'($urandom_range(1, 255));                   // only L1 set
   send_job(1'b1, random_syn(), l);
   collect_results(1);
   close_test("single_term", e0);
endtask

task automatic test_random_jobs();
   int e0;
   e0 = error_count;
   for (int n = 0; n < 10; n++)
   begin
      send_job(1'b1, random_syn(), random_lambda());
      collect_results(1);
   end
   close_test("random_jobs", e0);
endtask

task automatic test_shared_syndromes();
   int                   e0;
   rs_key_pkg::syn_vec_t s;
   e0 = error_count;
   s  = random_syn();
   load_syn(s);
   for (int n = 0; n < 3; n++)
      send_job(1'b0, s, random_lambda());               // held set without syn_valid
   @(posedge clk);                                      // third job lands in the buffer
   @(negedge clk);
   compare_flag("in_ready with two jobs waiting", in_ready, 1'b0);
   collect_results(3);
   close_test("shared_syndromes", e0);
endtask

task automatic test_simultaneous_load();
   int                   e0;
   rs_key_pkg::syn_vec_t s_new;
   e0    = error_count;
   s_new = random_syn();
   load_syn(random_syn());                              // stale set that should lose
   send_job(1'b1, s_new, random_lambda());
   collect_results(1);
   close_test("simultaneous_load", e0);
endtask

`endif

/* tb/omega_phi_tb.sv */
module omega_phi_tb;

   localparam int          CLK_PERIOD   = 4;
   localparam int          RESET_CYCLES = 3;
   localparam int          NUM_JOBS     = 16;            // jobs over all tests
   localparam int          JOB_CYCLES   = 100;           // bound per job, accept to result
   localparam logic [31:0] SEED         = 32'h78d889ea;

   // DUT inputs
   logic                    clk;
   logic                    reset;
   logic                    syn_valid;
   rs_key_pkg::syn_vec_t    syn;
   logic                    lambda_valid;
   rs_key_pkg::lambda_vec_t lambda;

   // DUT outputs
   logic                    in_ready;
   logic                    poly_ready;
   rs_key_pkg::omega_vec_t  omega;
   rs_key_pkg::phi_vec_t    phi;

   int error_count;
   int tests_passed;
   int tests_failed;

   rs_key_pkg::omega_vec_t  exp_omega [$];               // model results, in send order
   rs_key_pkg::phi_vec_t    exp_phi   [$];
   rs_key_pkg::omega_vec_t  got_omega [$];               // DUT results, in arrival order
   rs_key_pkg::phi_vec_t    got_phi   [$];

   omega_phi omega_phi_i
   (
      .clk          (clk),
      .reset        (reset),
      .syn_valid    (syn_valid),
      .syn          (syn),
      .lambda_valid (lambda_valid),
      .lambda       (lambda),
      .in_ready     (in_ready),
      .poly_ready   (poly_ready),
      .omega        (omega),
      .phi          (phi)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //////////////////////////////////////////////////
   // result capture, sampled mid-cycle
   //////////////////////////////////////////////////
   always @(negedge clk)
   begin
      if (!reset && poly_ready)
      begin
         got_omega.push_back(omega);                    // one entry per pulse
         got_phi.push_back(phi);
      end
   end

   `include "omega_phi_tb_tasks.svh"

   //////////////////////////////////////////////////
   // watchdog
   //////////////////////////////////////////////////
   initial
   begin
      #(NUM_JOBS * JOB_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD);
      $display("error at %0t: run timed out before all tests finished", $time);
      $display("*** FAILED ***");
      $finish;
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////
   initial
   begin
      error_count  = 0;
      tests_passed = 0;
      tests_failed = 0;
      clk          = 1'b0;
      reset        = 1'b1;
      syn_valid    = 1'b0;
      syn          = '0;
      lambda_valid = 1'b0;
      lambda       = '0;
      void'($urandom(SEED));                            // one seed for the whole run

      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      test_reset_state();
      test_zero_lambda();
      test_single_term();
      test_random_jobs();
      test_shared_syndromes();
      test_simultaneous_load();

      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (error_count == 0 && tests_failed == 0)
      begin
         $display("*** PASSED ***");
      end
      else
      begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+tb
logic/rs_key_pkg.sv
logic/key_capture.sv
logic/job_buffer.sv
logic/omega_engine.sv
logic/omega_phi.sv
tb/omega_phi_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f all.f --top-module omega_phi_tb

out=$(./obj_dir/Vomega_phi_tb)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
   exit 0
else
   exit 1
fi
